// ==== verilog.f ====
+incdir+common
common/rxfifo_pkg.sv
common/rxfifo_ptr_if.sv
hw/aib_bitsync.sv
fifo/aib_adaptrxdp_fifo_ptr.sv
fifo/aib_adaptrxdp_fifo_ram.sv
fifo/aib_adaptrxdp_fifo_flags.sv
hw/aib_adaptrxdp_fifo.sv
sim/aib_adaptrxdp_fifo_checker.sv
sim/aib_adaptrxdp_fifo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RX FIFO testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/10ps -f verilog.f \
   --top-module aib_adaptrxdp_fifo_tb -Mdir obj_dir &&
./obj_dir/Vaib_adaptrxdp_fifo_tb || exit 1

// ==== sim/aib_adaptrxdp_fifo_tb.sv ====
/* RX FIFO testbench */
`timescale 1ns/10ps
`include "rxfifo_cfg.svh"

module aib_adaptrxdp_fifo_tb;

   localparam int unsigned TIMEOUT_CYCLES = 6000;   // Three phases plus 400 random words

   logic               wr_clk = 1'b0;
   logic               rd_clk = 1'b0;
   logic               wr_rst_n;
   logic               rd_rst_n;
   logic               wr_en = 1'b0;
   logic               rd_en = 1'b0;
   rxfifo_pkg::data_t  wr_data = '0;
   logic               wr_full;
   logic               rd_empty;
   rxfifo_pkg::data_t  rd_data;
   rxfifo_pkg::level_t rd_level;

   int unsigned wr_acc    = 0;        // Accepted writes
   int unsigned rd_acc    = 0;        // Accepted pops
   int unsigned wr_target = 0;        // Writer stops at this count
   int unsigned rd_target = 0;        // Reader stops at this count
   int unsigned cycles    = 0;        // Read clock cycles so far
   int unsigned base;
   logic        wr_rand   = 1'b0;     // Random write enables
   logic        rd_rand   = 1'b0;     // Random read enables
   logic        fill_hit  = 1'b0;     // Previous write made 16 entries
   integer      seed      = 32'h5e2d39b5;   // Shared by both domain drivers

   always #20 rd_clk = ~rd_clk;   // 40 ns
   always #13 wr_clk = ~wr_clk;   // 26 ns and unrelated to rd_clk

   aib_adaptrxdp_fifo dut0 (
      .wr_clk (wr_clk), .wr_rst_n (wr_rst_n), .wr_en (wr_en), .wr_data (wr_data),
      .wr_full (wr_full), .rd_clk (rd_clk), .rd_rst_n (rd_rst_n), .rd_en (rd_en),
      .rd_data (rd_data), .rd_empty (rd_empty), .rd_level (rd_level)
   );

   //******************************
   // Reference and check
   //******************************
   // n-th written word scrambled so neighbours differ in many bits
   function automatic rxfifo_pkg::data_t word_for(input int unsigned n);
      logic [31:0] a;
      logic [31:0] b;
      a = n * 32'h9e3779b1;
      b = (n ^ 32'h3c6ef372) + 32'h7f4a7c15;
      return {a[7:0] ^ b[15:8], a ^ {b[23:0], b[31:24]}};
   endfunction

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("** Error @ %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
         $display("SOME TESTS FAILED");
         $fatal(1, "Value mismatch");
      end
   endtask

   //******************************
   // Write domain driver
   //******************************
   always @(posedge wr_clk) begin : write_drive
      logic        take;
      int unsigned nxt;
      take = wr_rst_n && wr_en && !wr_full;   // Word accepted on this edge
      nxt  = take ? wr_acc + 1 : wr_acc;
      if (fill_hit) check_value(64'(wr_full), 64'd1, "wr_full on 16th write");
      fill_hit <= take && ((nxt - rd_acc) == 16);
      wr_acc   <= nxt;
      wr_en    <= wr_rst_n && (nxt < wr_target) && (!wr_rand || ($random(seed) & 3) != 0);
      wr_data  <= word_for(nxt);               // Dropped words reuse the index
   end

   //******************************
   // Read domain driver and compare
   //******************************
   always @(posedge rd_clk) begin : read_drive
      int unsigned nxt;
      nxt   = (rd_rst_n && rd_en && !rd_empty) ? rd_acc + 1 : rd_acc;
      rd_en <= rd_rst_n && (nxt < rd_target) && (!rd_rand || ($random(seed) & 1) != 0);
   end

   always @(posedge rd_clk) begin : compare
      if (rd_rst_n && rd_en && !rd_empty) begin   // Pop while empty is not counted
         check_value(64'(rd_data), 64'(word_for(rd_acc)), "rd_data");
         rd_acc <= rd_acc + 1;
      end
      if (rd_rst_n) begin
         check_value(64'(rd_level > rxfifo_pkg::level_t'(`RXFIFO_DEPTH)), 64'd0,
                     "rd_level above depth");
      end
   end

   always @(posedge rd_clk) begin : watchdog
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Timeout, traffic did not finish within %0d read clock cycles",
                TIMEOUT_CYCLES);
      end
   end

   //******************************
   // Phase helpers
   //******************************
   task automatic wait_written(input int unsigned n);
      while (wr_acc != n) @(negedge wr_clk);
   endtask

   task automatic wait_read(input int unsigned n);
      while (rd_acc != n) @(negedge rd_clk);
   endtask

   // Let pointers cross while both sides idle and compare counts
   task automatic check_level(input string phase);
      repeat (6) @(posedge rd_clk);   // Covers register, sync and flag stages
      @(negedge rd_clk);
      check_value(64'(rd_level), 64'(wr_acc - rd_acc), {phase, " rd_level"});
      check_value(64'(rd_empty), 64'(wr_acc == rd_acc), {phase, " rd_empty"});
      check_value(64'(wr_full), 64'((wr_acc - rd_acc) == 16), {phase, " wr_full"});
   endtask

   initial begin
      wr_rst_n = 1'b0;
      rd_rst_n = 1'b0;
      fork
         begin
            repeat (8) @(posedge wr_clk);
            wr_rst_n <= 1'b1;
         end
         begin
            repeat (8) @(posedge rd_clk);
            rd_rst_n <= 1'b1;
         end
      join
      check_level("reset");                          // Empty and not full with level 0

      wr_target = 10;                                // Ordered transfer with reader idle
      wait_written(10);
      check_level("ordered fill");
      rd_target = 10;
      wait_read(10);
      check_value(64'(rd_empty), 64'd1, "rd_empty after last pop");
      check_level("ordered drain");

      base      = wr_acc;                            // Full and back-pressure
      wr_target = base + 24;
      while (!wr_full) @(negedge wr_clk);
      repeat (12) @(negedge wr_clk);                 // wr_en held against full
      check_value(64'(wr_acc - base), 64'd16, "writes accepted before full");
      check_value(64'(wr_full), 64'd1, "wr_full held");
      wr_target = wr_acc;
      rd_target = wr_acc;
      wait_read(rd_target);
      check_level("drain");

      base      = rd_acc;                            // Pops while empty
      rd_target = rd_acc + 6;
      repeat (10) @(negedge rd_clk);
      check_value(64'(rd_acc), 64'(base), "pops while empty");
      check_value(64'(rd_empty), 64'd1, "rd_empty held");
      rd_target = rd_acc;
      wr_target = wr_acc + 1;
      wait_written(wr_target);
      rd_target = rd_acc + 1;
      wait_read(rd_target);
      check_level("empty protection");

      wr_rand   = 1'b1;                              // Random concurrent traffic
      rd_rand   = 1'b1;
      wr_target = wr_acc + 400;
      rd_target = wr_target;
      wait_read(rd_target);
      wr_rand   = 1'b0;
      rd_rand   = 1'b0;
      check_level("random");

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== sim/aib_adaptrxdp_fifo_checker.sv ====
/* RX FIFO port checker */
`timescale 1ns/10ps
`include "rxfifo_cfg.svh"

module aib_adaptrxdp_fifo_checker (
   input logic                wr_clk,
   input logic                wr_rst_n,
   input logic                wr_full,
   input logic                rd_clk,
   input logic                rd_rst_n,
   input logic                rd_en,
   input rxfifo_pkg::data_t   rd_data,
   input logic                rd_empty,
   input rxfifo_pkg::level_t  rd_level
);

   // Count bounded by depth
   level_max: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      rd_level <= rxfifo_pkg::level_t'(`RXFIFO_DEPTH)) else $error("rd_level above depth");

   // Same registered source for flag and count
   empty_level: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      rd_empty == (rd_level == '0)) else $error("rd_empty disagrees with rd_level");

   // Show-ahead word held until popped
   data_hold: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      (!rd_empty && !rd_en) |=> $stable(rd_data)) else $error("rd_data moved without pop");

   // Flags right out of reset
   rd_reset: assert property (@(posedge rd_clk) $rose(rd_rst_n) |-> rd_empty)
      else $error("rd_empty low after reset");
   wr_reset: assert property (@(posedge wr_clk) $rose(wr_rst_n) |-> !wr_full)
      else $error("wr_full high after reset");

endmodule

bind aib_adaptrxdp_fifo aib_adaptrxdp_fifo_checker chk0 (
   .wr_clk (wr_clk), .wr_rst_n (wr_rst_n), .wr_full (wr_full), .rd_clk (rd_clk),
   .rd_rst_n (rd_rst_n), .rd_en (rd_en), .rd_data (rd_data), .rd_empty (rd_empty),
   .rd_level (rd_level)
);

// ==== hw/aib_adaptrxdp_fifo.sv ====
/* RX datapath elastic FIFO */
`timescale 1ns/10ps

module aib_adaptrxdp_fifo (
   // Write side
   input  logic                 wr_clk,     // Write domain clock
   input  logic                 wr_rst_n,   // Write domain reset, sync low
   input  logic                 wr_en,      // Write request
   input  rxfifo_pkg::data_t    wr_data,    // Incoming word
   output logic                 wr_full,    // Back-pressure
   // Read side
   input  logic                 rd_clk,     // Read domain clock
   input  logic                 rd_rst_n,   // Read domain reset, sync low
   input  logic                 rd_en,      // Consume head word
   output rxfifo_pkg::data_t    rd_data,    // Head word when not empty
   output logic                 rd_empty,   // No word visible
   output rxfifo_pkg::level_t   rd_level    // Entries seen by reader
);

   rxfifo_ptr_if ptr_if ();   // Internal pointer bundle

   // Pointers and Gray crossing
   aib_adaptrxdp_fifo_ptr fifo_ptr (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .ptr      (ptr_if)
   );

   // Storage
   aib_adaptrxdp_fifo_ram fifo_ram (
      .wr_clk  (wr_clk),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .mem     (ptr_if)
   );

   // Flags and enable qualification
   aib_adaptrxdp_fifo_flags fifo_flags (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .wr_en    (wr_en),
      .rd_en    (rd_en),
      .wr_full  (wr_full),
      .rd_empty (rd_empty),
      .rd_level (rd_level),
      .flg      (ptr_if)
   );

endmodule

// ==== fifo/aib_adaptrxdp_fifo_flags.sv ====
/* RX FIFO full and empty flags */
`timescale 1ns/10ps
`include "rxfifo_cfg.svh"

module aib_adaptrxdp_fifo_flags (
   input  logic                 wr_clk,     // Write domain clock
   input  logic                 wr_rst_n,   // Write domain reset
   input  logic                 rd_clk,     // Read domain clock
   input  logic                 rd_rst_n,   // Read domain reset
   input  logic                 wr_en,      // Raw write request
   input  logic                 rd_en,      // Raw read request
   output logic                 wr_full,    // No room for another word
   output logic                 rd_empty,   // Nothing visible to read
   output rxfifo_pkg::level_t   rd_level,   // Registered read side count
   rxfifo_ptr_if.flags_mp       flg         // Levels in, qualified enables out
);

   logic                wr_full_q;
   logic                rd_empty_q;
   rxfifo_pkg::level_t  rd_level_q;

   // Blocked when full or empty
   assign flg.wr_push = wr_en & ~wr_full_q;
   assign flg.rd_pop  = rd_en & ~rd_empty_q;

   //******************************
   // Write domain
   //******************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) wr_full_q <= 1'b0;
      else           wr_full_q <= (flg.wr_level == rxfifo_pkg::level_t'(`RXFIFO_DEPTH));
   end

   //******************************
   // Read domain
   //******************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_empty_q <= 1'b1;   // Nothing stored yet
         rd_level_q <= '0;
      end
      else begin
         rd_empty_q <= (flg.rd_level == '0);
         rd_level_q <= flg.rd_level;   // Same source as empty, stays consistent
      end
   end

   assign wr_full  = wr_full_q;
   assign rd_empty = rd_empty_q;
   assign rd_level = rd_level_q;

endmodule

// ==== fifo/aib_adaptrxdp_fifo_ram.sv ====
/* RX FIFO register array */
`timescale 1ns/10ps
`include "rxfifo_cfg.svh"

module aib_adaptrxdp_fifo_ram (
   input  logic                wr_clk,    // Write domain clock
   input  rxfifo_pkg::data_t   wr_data,   // Word to store
   output rxfifo_pkg::data_t   rd_data,   // Word at read pointer, show-ahead
   rxfifo_ptr_if.ram_mp        mem        // Push, write select, read index
);

   rxfifo_pkg::data_t entry_q [`RXFIFO_DEPTH];   // Storage, no reset needed

   //******************************
   // Write port
   //******************************
   // One-hot select means one entry loads per push
   always_ff @(posedge wr_clk) begin
      for (int i = 0; i < `RXFIFO_DEPTH; i++) begin
         if (mem.wr_push && mem.wr_ptr_one_hot[i]) begin
            entry_q[i] <= wr_data;
         end
      end
   end

   //******************************
   // Read port
   //******************************
   // Plain mux, data valid as soon as the pointer settles
   assign rd_data = entry_q[mem.rd_ptr_bin];

endmodule

// ==== fifo/aib_adaptrxdp_fifo_ptr.sv ====
/* RX FIFO pointer block */
`timescale 1ns/10ps
`include "rxfifo_cfg.svh"

module aib_adaptrxdp_fifo_ptr (
   input  logic          wr_clk,     // Write domain clock
   input  logic          wr_rst_n,   // Write domain reset
   input  logic          rd_clk,     // Read domain clock
   input  logic          rd_rst_n,   // Read domain reset
   rxfifo_ptr_if.ptr_mp  ptr         // Enables in, pointers and levels out
);

   rxfifo_pkg::ptr_t  wr_addr_bin, wr_addr_gry;          // Write pointer regs
   rxfifo_pkg::ptr_t  rd_addr_bin, rd_addr_gry;          // Read pointer regs
   rxfifo_pkg::ptr_t  wr_addr_bin_nxt, wr_addr_gry_nxt;
   rxfifo_pkg::ptr_t  rd_addr_bin_nxt, rd_addr_gry_nxt;
   rxfifo_pkg::ptr_t  wr_addr_gry_sync, rd_addr_gry_sync; // Crossed Gray values
   rxfifo_pkg::ptr_t  wr_addr_bin_sync, rd_addr_bin_sync; // Back in binary
   rxfifo_pkg::addr_t wr_addr_mem;                        // Write slot index

   //******************************
   // Write domain pointers
   //******************************
   assign wr_addr_bin_nxt = wr_addr_bin + rxfifo_pkg::ptr_t'(ptr.wr_push);
   assign wr_addr_gry_nxt = (wr_addr_bin_nxt >> 1) ^ wr_addr_bin_nxt;   // Bin to Gray

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_addr_bin <= '0;
         wr_addr_gry <= '0;
      end
      else begin
         wr_addr_bin <= wr_addr_bin_nxt;
         wr_addr_gry <= wr_addr_gry_nxt;   // Registered so the crossing sees clean bits
      end
   end

   assign wr_addr_mem        = wr_addr_bin[`RXFIFO_AWIDTH-1:0];
   assign ptr.wr_ptr_one_hot = bin_to_onehot(wr_addr_mem);

   // Read pointer into write domain
   aib_bitsync bitsync2_wr (
      .clk      (wr_clk),
      .rst_n    (wr_rst_n),
      .data_in  (rd_addr_gry),
      .data_out (rd_addr_gry_sync)
   );

   assign rd_addr_bin_sync = greytobin(rd_addr_gry_sync);
   assign ptr.wr_level     = rxfifo_pkg::level_t'(wr_addr_bin_nxt - rd_addr_bin_sync);

   //******************************
   // Read domain pointers
   //******************************
   assign rd_addr_bin_nxt = rd_addr_bin + rxfifo_pkg::ptr_t'(ptr.rd_pop);
   assign rd_addr_gry_nxt = (rd_addr_bin_nxt >> 1) ^ rd_addr_bin_nxt;

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_addr_bin <= '0;
         rd_addr_gry <= '0;
      end
      else begin
         rd_addr_bin <= rd_addr_bin_nxt;
         rd_addr_gry <= rd_addr_gry_nxt;
      end
   end

   assign ptr.rd_ptr_bin = rd_addr_bin[`RXFIFO_AWIDTH-1:0];   // Show-ahead slot

   // Write pointer into read domain
   aib_bitsync bitsync2_rd (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .data_in  (wr_addr_gry),
      .data_out (wr_addr_gry_sync)
   );

   assign wr_addr_bin_sync = greytobin(wr_addr_gry_sync);
   // Uses next read pointer so a pop of the last word reads zero at once
   assign ptr.rd_level     = rxfifo_pkg::level_t'(wr_addr_bin_sync - rd_addr_bin_nxt);

   //******************************
   // Helpers
   //******************************
   function automatic rxfifo_pkg::ptr_t greytobin(input rxfifo_pkg::ptr_t gry);
      rxfifo_pkg::ptr_t bin;
      for (int i = 0; i <= `RXFIFO_AWIDTH; i++) begin
         bin[i] = ^(gry >> i);   // XOR of this bit and all above
      end
      return bin;
   endfunction

   function automatic rxfifo_pkg::onehot_t bin_to_onehot(input rxfifo_pkg::addr_t idx);
      rxfifo_pkg::onehot_t sel;
      sel      = '0;
      sel[idx] = 1'b1;
      return sel;
   endfunction

endmodule

// ==== hw/aib_bitsync.sv ====
/* Gray pointer synchronizer */
`timescale 1ns/10ps

module aib_bitsync (
   input  logic               clk,        // Destination clock
   input  logic               rst_n,      // Destination reset, sync low
   input  rxfifo_pkg::ptr_t   data_in,    // Gray value from source domain
   output rxfifo_pkg::ptr_t   data_out    // Gray value, now safe to use
);

   rxfifo_pkg::ptr_t meta_q;   // First stage, may go metastable
   rxfifo_pkg::ptr_t sync_q;   // Second stage, settled

   // Only one bit moves per source update, so two flops suffice
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         meta_q <= '0;
         sync_q <= '0;
      end
      else begin
         meta_q <= data_in;
         sync_q <= meta_q;
      end
   end

   assign data_out = sync_q;

endmodule

// ==== common/rxfifo_ptr_if.sv ====
/* Pointer and level bundle */
`timescale 1ns/10ps

interface rxfifo_ptr_if;

   // Qualified enables
   logic                  wr_push;          // Write accepted this wr_clk
   logic                  rd_pop;           // Read accepted this rd_clk

   // Memory addressing
   rxfifo_pkg::onehot_t   wr_ptr_one_hot;   // Decoded write slot
   rxfifo_pkg::addr_t     rd_ptr_bin;       // Read slot, low bits of read pointer

   // Fill counts, each in its own domain
   rxfifo_pkg::level_t    wr_level;         // Write side view
   rxfifo_pkg::level_t    rd_level;         // Read side view

   // Pointer block
   modport ptr_mp (
      input  wr_push, rd_pop,
      output wr_ptr_one_hot, rd_ptr_bin, wr_level, rd_level
   );

   // Register array
   modport ram_mp (
      input  wr_push, wr_ptr_one_hot, rd_ptr_bin
   );

   // Flag block
   modport flags_mp (
      input  wr_level, rd_level,
      output wr_push, rd_pop
   );

endinterface

// ==== common/rxfifo_pkg.sv ====
/* RX FIFO types */

package rxfifo_pkg;

`include "rxfifo_cfg.svh"

   //******************************
   // Pointer and address types
   //******************************
   typedef logic [`RXFIFO_AWIDTH-1:0] addr_t;    // Memory index
   typedef logic [`RXFIFO_AWIDTH:0]   ptr_t;     // Index plus wrap bit, binary or Gray

   //******************************
   // Count and select types
   //******************************
   typedef logic [`RXFIFO_AWIDTH:0]   level_t;   // Holds 0..DEPTH inclusive
   typedef logic [`RXFIFO_DEPTH-1:0]  onehot_t;  // One bit per entry

   // Payload
   typedef logic [`RXFIFO_DWIDTH-1:0] data_t;    // Lane word

endpackage

// ==== common/rxfifo_cfg.svh ====
/* RX FIFO configuration */

`ifndef RXFIFO_CFG_SVH
`define RXFIFO_CFG_SVH

// Address width, the one knob meant to change
`define RXFIFO_AWIDTH 4

// Entries, always 2**RXFIFO_AWIDTH
`define RXFIFO_DEPTH  16

// One adapter lane word
`define RXFIFO_DWIDTH 40

`endif
